// ==== Bender.yml ====
package:
  name: rab_core

export_include_dirs:
  - src

sources:
  - src/rab_pkg.sv
  - src/rab_port_arbiter.sv
  - src/rab_burst_range.sv
  - src/rab_slice_cfg.sv
  - src/rab_slice_match.sv
  - src/rab_port_fsm.sv
  - src/rab_core.sv
  - target: test
    files:
      - verification/rab_core_properties.sv
      - verification/rab_core_tb.sv

// ==== sources.f ====
+incdir+src
src/rab_pkg.sv
src/rab_port_arbiter.sv
src/rab_burst_range.sv
src/rab_slice_cfg.sv
src/rab_slice_match.sv
src/rab_port_fsm.sv
src/rab_core.sv
verification/rab_core_properties.sv
verification/rab_core_tb.sv

// ==== src/rab_burst_range.sv ====
/*
 * aligned start and last byte address of the chosen burst
 */
`timescale 1ns/1ps
`include "rab_settings.svh"

module rab_burst_range
(
  input  rab_pkg::virt_addr_t  req_addr,
  input  rab_pkg::burst_len_t  req_len,
  input  rab_pkg::burst_size_t req_size,
  output rab_pkg::virt_addr_t  req_last
);

  localparam int unsigned BEAT_BITS = `RAB_BEAT_BITS;
  localparam int unsigned VA_W      = `RAB_VIRT_ADDR_WIDTH;

  logic [BEAT_BITS-1:0] beat_mask;
  rab_pkg::virt_addr_t  aligned_addr;
  rab_pkg::virt_addr_t  burst_bytes;

  always_comb
  begin
    // keep only the offset bits at or above the transfer size
    beat_mask = {BEAT_BITS{1'b1}} << req_size;

    aligned_addr = {req_addr[VA_W-1:BEAT_BITS], req_addr[BEAT_BITS-1:0] & beat_mask};

    burst_bytes = (rab_pkg::virt_addr_t'(req_len) + 1'b1) << req_size;

    // address of the last byte touched
    req_last = aligned_addr + burst_bytes - 1'b1;
  end

endmodule

// ==== src/rab_core.sv ====
/*
 * single-port remapping address block: arbiter, burst range,
 * slice table, slice match and port state machine
 */
`timescale 1ns/1ps

module rab_core
(
  input  logic                 Clk_CI,
  input  logic                 Rst_RBI,
  input  logic                 cfg_wen,
  input  rab_pkg::cfg_idx_t    cfg_idx,
  input  rab_pkg::cfg_word_t   cfg_wdata,
  input  logic                 port1_addr_valid,
  input  rab_pkg::virt_addr_t  port1_addr,
  input  rab_pkg::burst_len_t  port1_len,
  input  rab_pkg::burst_size_t port1_size,
  input  logic                 port1_type,
  input  rab_pkg::user_t       port1_ctrl,
  input  logic                 port1_sent,
  output logic                 port1_accept,
  output logic                 port1_drop,
  output rab_pkg::phys_addr_t  port1_out_addr,
  input  logic                 port2_addr_valid,
  input  rab_pkg::virt_addr_t  port2_addr,
  input  rab_pkg::burst_len_t  port2_len,
  input  rab_pkg::burst_size_t port2_size,
  input  logic                 port2_type,
  input  rab_pkg::user_t       port2_ctrl,
  input  logic                 port2_sent,
  output logic                 port2_accept,
  output logic                 port2_drop,
  output rab_pkg::phys_addr_t  port2_out_addr,
  output logic                 int_miss,
  output logic                 int_prot,
  output logic                 int_multi
);

  logic                     sel_port1;
  logic                     served_port1;
  logic                     served_port2;
  rab_pkg::virt_addr_t      req_addr;
  rab_pkg::virt_addr_t      req_last;
  rab_pkg::burst_len_t      req_len;
  rab_pkg::burst_size_t     req_size;
  logic                     req_write;
  logic                     req_bypass;
  rab_pkg::slice_virt_arr_t slice_min;
  rab_pkg::slice_virt_arr_t slice_max;
  rab_pkg::slice_phys_arr_t slice_offset;
  rab_pkg::slice_vec_t      slice_en;
  rab_pkg::slice_vec_t      slice_rd_en;
  rab_pkg::slice_vec_t      slice_wr_en;
  rab_pkg::lookup_result_e  lookup_result;
  rab_pkg::phys_addr_t      phys_addr;
  rab_pkg::phys_addr_t      out_addr;

  rab_port_arbiter arbiter_i
  (
    .Clk_CI           (Clk_CI),
    .Rst_RBI          (Rst_RBI),
    .port1_addr_valid (port1_addr_valid),
    .port2_addr_valid (port2_addr_valid),
    .port1_addr       (port1_addr),
    .port2_addr       (port2_addr),
    .port1_len        (port1_len),
    .port2_len        (port2_len),
    .port1_size       (port1_size),
    .port2_size       (port2_size),
    .port1_type       (port1_type),
    .port2_type       (port2_type),
    .port1_ctrl       (port1_ctrl),
    .port2_ctrl       (port2_ctrl),
    .served_port1     (served_port1),
    .served_port2     (served_port2),
    .sel_port1        (sel_port1),
    .req_addr         (req_addr),
    .req_len          (req_len),
    .req_size         (req_size),
    .req_write        (req_write),
    .req_bypass       (req_bypass)
  );

  rab_burst_range range_i
  (
    .req_addr (req_addr),
    .req_len  (req_len),
    .req_size (req_size),
    .req_last (req_last)
  );

  rab_slice_cfg cfg_i
  (
    .Clk_CI       (Clk_CI),
    .Rst_RBI      (Rst_RBI),
    .cfg_wen      (cfg_wen),
    .cfg_idx      (cfg_idx),
    .cfg_wdata    (cfg_wdata),
    .slice_min    (slice_min),
    .slice_max    (slice_max),
    .slice_offset (slice_offset),
    .slice_en     (slice_en),
    .slice_rd_en  (slice_rd_en),
    .slice_wr_en  (slice_wr_en)
  );

  rab_slice_match match_i
  (
    .req_addr      (req_addr),
    .req_last      (req_last),
    .req_write     (req_write),
    .slice_min     (slice_min),
    .slice_max     (slice_max),
    .slice_offset  (slice_offset),
    .slice_en      (slice_en),
    .slice_rd_en   (slice_rd_en),
    .slice_wr_en   (slice_wr_en),
    .lookup_result (lookup_result),
    .phys_addr     (phys_addr)
  );

  rab_port_fsm fsm_i
  (
    .Clk_CI           (Clk_CI),
    .Rst_RBI          (Rst_RBI),
    .port1_addr_valid (port1_addr_valid),
    .port2_addr_valid (port2_addr_valid),
    .port1_sent       (port1_sent),
    .port2_sent       (port2_sent),
    .sel_port1        (sel_port1),
    .req_bypass       (req_bypass),
    .req_addr         (req_addr),
    .lookup_result    (lookup_result),
    .phys_addr        (phys_addr),
    .port1_accept     (port1_accept),
    .port1_drop       (port1_drop),
    .port2_accept     (port2_accept),
    .port2_drop       (port2_drop),
    .served_port1     (served_port1),
    .served_port2     (served_port2),
    .int_miss         (int_miss),
    .int_prot         (int_prot),
    .int_multi        (int_multi),
    .out_addr         (out_addr)
  );

  // one translated address shared by both masters
  assign port1_out_addr = out_addr;
  assign port2_out_addr = out_addr;

endmodule

// ==== src/rab_pkg.sv ====
/*
 * address, burst, configuration and lookup-result types
 */
`include "rab_settings.svh"

package rab_pkg;

  typedef logic [`RAB_VIRT_ADDR_WIDTH-1:0] virt_addr_t;
  typedef logic [`RAB_PHYS_ADDR_WIDTH-1:0] phys_addr_t;

  // AXI style burst description
  typedef logic [7:0] burst_len_t;   // beats minus one
  typedef logic [2:0] burst_size_t;  // log2 of bytes per beat
  typedef logic [`RAB_USER_WIDTH-1:0] user_t;

  typedef logic [`RAB_CFG_DATA_WIDTH-1:0] cfg_word_t;
  typedef logic [$clog2(`RAB_N_SLICES*`RAB_REGS_PER_SLICE)-1:0] cfg_idx_t;

  typedef logic [`RAB_N_SLICES-1:0] slice_vec_t;  // one bit per slice
  typedef virt_addr_t [`RAB_N_SLICES-1:0] slice_virt_arr_t;
  typedef phys_addr_t [`RAB_N_SLICES-1:0] slice_phys_arr_t;

  typedef enum logic [1:0]
  {
    LOOKUP_HIT   = 2'd0,
    LOOKUP_MISS  = 2'd1,
    LOOKUP_PROT  = 2'd2,
    LOOKUP_MULTI = 2'd3
  } lookup_result_e;

endpackage

// ==== src/rab_port_arbiter.sv ====
/*
 * alternating-priority choice between port1 and port2,
 * multiplexing of the chosen request and bypass detection
 */
`timescale 1ns/1ps

module rab_port_arbiter
(
  input  logic                 Clk_CI,
  input  logic                 Rst_RBI,
  input  logic                 port1_addr_valid,
  input  logic                 port2_addr_valid,
  input  rab_pkg::virt_addr_t  port1_addr,
  input  rab_pkg::virt_addr_t  port2_addr,
  input  rab_pkg::burst_len_t  port1_len,
  input  rab_pkg::burst_len_t  port2_len,
  input  rab_pkg::burst_size_t port1_size,
  input  rab_pkg::burst_size_t port2_size,
  input  logic                 port1_type,
  input  logic                 port2_type,
  input  rab_pkg::user_t       port1_ctrl,
  input  rab_pkg::user_t       port2_ctrl,
  input  logic                 served_port1,
  input  logic                 served_port2,
  output logic                 sel_port1,
  output rab_pkg::virt_addr_t  req_addr,
  output rab_pkg::burst_len_t  req_len,
  output rab_pkg::burst_size_t req_size,
  output logic                 req_write,
  output logic                 req_bypass
);

  logic           prio_port1;  // port1 wins when both are valid
  rab_pkg::user_t req_ctrl;

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      prio_port1 <= 1'b1;
    else if (served_port1)
      prio_port1 <= 1'b0;  // hand over to port2
    else if (served_port2)
      prio_port1 <= 1'b1;
  end

  // a lone valid port is always taken
  assign sel_port1 = (prio_port1 & port1_addr_valid) | ~port2_addr_valid;

  always_comb
  begin
    req_addr  = sel_port1 ? port1_addr : port2_addr;
    req_len   = sel_port1 ? port1_len  : port2_len;
    req_size  = sel_port1 ? port1_size : port2_size;
    req_write = sel_port1 ? port1_type : port2_type;
    req_ctrl  = sel_port1 ? port1_ctrl : port2_ctrl;
  end

  assign req_bypass = (req_ctrl == '1);  // untranslated access

endmodule

// ==== src/rab_port_fsm.sv ====
/*
 * port state machine: accept or drop decision, registered output
 * address, wait for sent and interrupt pulses
 */
`timescale 1ns/1ps

module rab_port_fsm
(
  input  logic                    Clk_CI,
  input  logic                    Rst_RBI,
  input  logic                    port1_addr_valid,
  input  logic                    port2_addr_valid,
  input  logic                    port1_sent,
  input  logic                    port2_sent,
  input  logic                    sel_port1,
  input  logic                    req_bypass,
  input  rab_pkg::virt_addr_t     req_addr,
  input  rab_pkg::lookup_result_e lookup_result,
  input  rab_pkg::phys_addr_t     phys_addr,
  output logic                    port1_accept,
  output logic                    port1_drop,
  output logic                    port2_accept,
  output logic                    port2_drop,
  output logic                    served_port1,
  output logic                    served_port2,
  output logic                    int_miss,
  output logic                    int_prot,
  output logic                    int_multi,
  output rab_pkg::phys_addr_t     out_addr
);

  typedef enum logic [1:0] {IDLE, DECIDE, WAIT_SENT} state_e;

  state_e                  state_q, state_d;
  logic                    sel_port1_q;  // port under service
  logic                    accept_q;
  rab_pkg::lookup_result_e result_q;
  rab_pkg::phys_addr_t     out_addr_q;
  logic                    any_valid;
  logic                    chosen_sent;
  logic                    decide;

  assign any_valid   = port1_addr_valid | port2_addr_valid;
  assign chosen_sent = sel_port1_q ? port1_sent : port2_sent;
  assign decide      = (state_q == DECIDE);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (any_valid) state_d = DECIDE;
      DECIDE:    state_d = accept_q ? WAIT_SENT : IDLE;
      WAIT_SENT: if (chosen_sent) state_d = IDLE;  // master issued the transfer
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      state_q     <= IDLE;
      sel_port1_q <= 1'b1;
      accept_q    <= 1'b0;
      result_q    <= rab_pkg::LOOKUP_MISS;
      out_addr_q  <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == IDLE && any_valid)
      begin
        sel_port1_q <= sel_port1;
        accept_q    <= req_bypass || (lookup_result == rab_pkg::LOOKUP_HIT);
        result_q    <= lookup_result;
        // bypass passes the virtual address through
        out_addr_q  <= req_bypass ? rab_pkg::phys_addr_t'(req_addr) : phys_addr;
      end
    end
  end

  assign port1_accept = decide &  sel_port1_q &  accept_q;
  assign port1_drop   = decide &  sel_port1_q & ~accept_q;
  assign port2_accept = decide & ~sel_port1_q &  accept_q;
  assign port2_drop   = decide & ~sel_port1_q & ~accept_q;

  assign served_port1 = decide &  sel_port1_q;
  assign served_port2 = decide & ~sel_port1_q;

  // cause of a drop
  assign int_miss  = decide & ~accept_q & (result_q == rab_pkg::LOOKUP_MISS);
  assign int_prot  = decide & ~accept_q & (result_q == rab_pkg::LOOKUP_PROT);
  assign int_multi = decide & ~accept_q & (result_q == rab_pkg::LOOKUP_MULTI);

  assign out_addr = out_addr_q;  // held through WAIT_SENT

endmodule

// ==== src/rab_settings.svh ====
/*
 * widths, slice count and configuration register map
 * of the remapping address block
 */
`ifndef RAB_SETTINGS_SVH
`define RAB_SETTINGS_SVH

`define RAB_VIRT_ADDR_WIDTH 32
`define RAB_PHYS_ADDR_WIDTH 40
`define RAB_DATA_WIDTH      64
`define RAB_BEAT_BITS       $clog2(`RAB_DATA_WIDTH/8)  // byte offset bits within a beat
`define RAB_USER_WIDTH      6                          // all ones selects bypass

`define RAB_N_SLICES        4
`define RAB_CFG_DATA_WIDTH  64
`define RAB_REGS_PER_SLICE  4

// register offsets inside one slice
`define RAB_REG_ADDR_MIN    0
`define RAB_REG_ADDR_MAX    1
`define RAB_REG_OFFSET      2
`define RAB_REG_FLAGS       3

`define RAB_FLAG_EN         0
`define RAB_FLAG_RD         1
`define RAB_FLAG_WR         2

`endif

// ==== src/rab_slice_cfg.sv ====
/*
 * slice register file: bounds, offset and flags per slice,
 * written through the configuration strobe
 */
`timescale 1ns/1ps
`include "rab_settings.svh"

module rab_slice_cfg
(
  input  logic                     Clk_CI,
  input  logic                     Rst_RBI,
  input  logic                     cfg_wen,
  input  rab_pkg::cfg_idx_t        cfg_idx,
  input  rab_pkg::cfg_word_t       cfg_wdata,
  output rab_pkg::slice_virt_arr_t slice_min,
  output rab_pkg::slice_virt_arr_t slice_max,
  output rab_pkg::slice_phys_arr_t slice_offset,
  output rab_pkg::slice_vec_t      slice_en,
  output rab_pkg::slice_vec_t      slice_rd_en,
  output rab_pkg::slice_vec_t      slice_wr_en
);

  localparam int unsigned N_SLICES = `RAB_N_SLICES;
  localparam int unsigned N_REGS   = `RAB_REGS_PER_SLICE;

  // register select, index = slice * regs per slice + offset
  function automatic logic sel_reg(input int unsigned slice, input int unsigned offs);
    return cfg_wen && (cfg_idx == rab_pkg::cfg_idx_t'(slice*N_REGS + offs));
  endfunction

  // address fields, truncated to their width
  always_ff @(posedge Clk_CI)
  begin
    for (int unsigned s = 0; s < N_SLICES; s++)
    begin
      if (sel_reg(s, `RAB_REG_ADDR_MIN))
        slice_min[s] <= rab_pkg::virt_addr_t'(cfg_wdata);
      if (sel_reg(s, `RAB_REG_ADDR_MAX))
        slice_max[s] <= rab_pkg::virt_addr_t'(cfg_wdata);
      if (sel_reg(s, `RAB_REG_OFFSET))
        slice_offset[s] <= rab_pkg::phys_addr_t'(cfg_wdata);
    end
  end

  // flags register, every slice off out of reset
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      slice_en    <= '0;
      slice_rd_en <= '0;
      slice_wr_en <= '0;
    end
    else
    begin
      for (int unsigned s = 0; s < N_SLICES; s++)
      begin
        if (sel_reg(s, `RAB_REG_FLAGS))
        begin
          slice_en[s]    <= cfg_wdata[`RAB_FLAG_EN];
          slice_rd_en[s] <= cfg_wdata[`RAB_FLAG_RD];
          slice_wr_en[s] <= cfg_wdata[`RAB_FLAG_WR];
        end
      end
    end
  end

endmodule

// ==== src/rab_slice_match.sv ====
/*
 * range and permission check of the burst against all slices,
 * lookup result and translated physical address
 */
`timescale 1ns/1ps

module rab_slice_match
(
  input  rab_pkg::virt_addr_t      req_addr,
  input  rab_pkg::virt_addr_t      req_last,
  input  logic                     req_write,
  input  rab_pkg::slice_virt_arr_t slice_min,
  input  rab_pkg::slice_virt_arr_t slice_max,
  input  rab_pkg::slice_phys_arr_t slice_offset,
  input  rab_pkg::slice_vec_t      slice_en,
  input  rab_pkg::slice_vec_t      slice_rd_en,
  input  rab_pkg::slice_vec_t      slice_wr_en,
  output rab_pkg::lookup_result_e  lookup_result,
  output rab_pkg::phys_addr_t      phys_addr
);

  localparam int unsigned N_SLICES = $bits(rab_pkg::slice_vec_t);

  rab_pkg::slice_vec_t hit;
  rab_pkg::slice_vec_t allowed;   // needed permission per slice
  logic                multi_hit;

  always_comb
  begin
    for (int unsigned s = 0; s < N_SLICES; s++)
    begin
      // whole burst inside the slice
      hit[s] = slice_en[s] && (slice_min[s] <= req_addr) && (req_last <= slice_max[s]);
    end
  end

  assign allowed   = req_write ? slice_wr_en : slice_rd_en;
  assign multi_hit = |(hit & (hit - 1'b1));  // more than one bit set

  always_comb
  begin
    if (hit == '0)
      lookup_result = rab_pkg::LOOKUP_MISS;
    else if (multi_hit)
      lookup_result = rab_pkg::LOOKUP_MULTI;
    else if ((hit & allowed) == '0)
      lookup_result = rab_pkg::LOOKUP_PROT;
    else
      lookup_result = rab_pkg::LOOKUP_HIT;
  end

  // offset into the slice plus its physical base
  always_comb
  begin
    phys_addr = '0;
    for (int unsigned s = 0; s < N_SLICES; s++)
    begin
      if (hit[s])
        phys_addr = rab_pkg::phys_addr_t'(req_addr - slice_min[s]) + slice_offset[s];
    end
  end

endmodule

// ==== verification/rab_core_properties.sv ====
/*
 * concurrent assertions on the port handshake of rab_core
 */
`timescale 1ns/1ps

module rab_core_properties
(
  input logic                Clk_CI,
  input logic                Rst_RBI,
  input logic                port1_accept,
  input logic                port1_drop,
  input logic                port2_accept,
  input logic                port2_drop,
  input logic                port1_sent,
  input logic                port2_sent,
  input logic                int_miss,
  input logic                int_prot,
  input logic                int_multi,
  input rab_pkg::phys_addr_t port1_out_addr
);

  logic        waiting_q;     // accepted burst not yet sent
  int unsigned fail_cnt = 0;  // failed assertions so far

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      waiting_q <= 1'b0;
    else if (port1_accept || port2_accept)
      waiting_q <= 1'b1;
    else if (port1_sent || port2_sent)
      waiting_q <= 1'b0;
  end

  port1_one_decision: assert property (
    @(posedge Clk_CI) disable iff (!Rst_RBI) !(port1_accept && port1_drop))
  else
  begin
    $error("port1 accept and drop high together");
    fail_cnt++;
  end

  port2_one_decision: assert property (
    @(posedge Clk_CI) disable iff (!Rst_RBI) !(port2_accept && port2_drop))
  else
  begin
    $error("port2 accept and drop high together");
    fail_cnt++;
  end

  one_port_served: assert property (
    @(posedge Clk_CI) disable iff (!Rst_RBI)
      !((port1_accept || port1_drop) && (port2_accept || port2_drop)))
  else
  begin
    $error("both ports served in one cycle");
    fail_cnt++;
  end

  irq_with_drop: assert property (
    @(posedge Clk_CI) disable iff (!Rst_RBI)
      (int_miss || int_prot || int_multi) |-> (port1_drop || port2_drop))
  else
  begin
    $error("interrupt without a drop");
    fail_cnt++;
  end

  // both out_addr ports carry the same register
  addr_held: assert property (
    @(posedge Clk_CI) disable iff (!Rst_RBI) waiting_q |=> $stable(port1_out_addr))
  else
  begin
    $error("out_addr changed while waiting for sent");
    fail_cnt++;
  end

endmodule

bind rab_core rab_core_properties props_i (.*);

// ==== verification/rab_core_tb.sv ====
/*
 * testbench of rab_core: slice programming, burst table with a
 * reference lookup, compare tasks and watchdog
 */
`timescale 1ns/1ps
`include "rab_settings.svh"

module rab_core_tb;

  localparam int N_FIXED    = 15;
  localparam int N_RAND     = 6;
  localparam int N_ROWS     = N_FIXED + N_RAND;
  localparam int REPROG_ROW = 13;                          // slice 1 rewritten before this row
  localparam int N_CFG      = 5 * `RAB_REGS_PER_SLICE;     // five slice writes in total

  localparam rab_pkg::lookup_result_e HIT   = rab_pkg::LOOKUP_HIT;
  localparam rab_pkg::lookup_result_e MISS  = rab_pkg::LOOKUP_MISS;
  localparam rab_pkg::lookup_result_e PROT  = rab_pkg::LOOKUP_PROT;
  localparam rab_pkg::lookup_result_e MULTI = rab_pkg::LOOKUP_MULTI;

  typedef struct {
    logic                 valid;
    rab_pkg::virt_addr_t  addr;
    rab_pkg::burst_len_t  len;
    rab_pkg::burst_size_t size;
    logic                 write;
    rab_pkg::user_t       ctrl;
  } req_t;

  typedef struct {
    req_t                    p1;
    req_t                    p2;
    rab_pkg::lookup_result_e exp_res;  // port served first
    logic                    exp_port1;
    rab_pkg::phys_addr_t     exp_addr;
    bit                      use_ref;  // expectation from the reference lookup
  } row_t;

  logic                 Clk_CI;
  logic                 Rst_RBI;
  logic                 cfg_wen;
  rab_pkg::cfg_idx_t    cfg_idx;
  rab_pkg::cfg_word_t   cfg_wdata;
  logic                 port1_addr_valid;
  rab_pkg::virt_addr_t  port1_addr;
  rab_pkg::burst_len_t  port1_len;
  rab_pkg::burst_size_t port1_size;
  logic                 port1_type;
  rab_pkg::user_t       port1_ctrl;
  logic                 port1_sent;
  logic                 port1_accept;
  logic                 port1_drop;
  rab_pkg::phys_addr_t  port1_out_addr;
  logic                 port2_addr_valid;
  rab_pkg::virt_addr_t  port2_addr;
  rab_pkg::burst_len_t  port2_len;
  rab_pkg::burst_size_t port2_size;
  logic                 port2_type;
  rab_pkg::user_t       port2_ctrl;
  logic                 port2_sent;
  logic                 port2_accept;
  logic                 port2_drop;
  rab_pkg::phys_addr_t  port2_out_addr;
  logic                 int_miss;
  logic                 int_prot;
  logic                 int_multi;

  // copy of the programmed slice table
  rab_pkg::slice_virt_arr_t ref_min;
  rab_pkg::slice_virt_arr_t ref_max;
  rab_pkg::slice_phys_arr_t ref_off;
  rab_pkg::slice_vec_t      ref_en;
  rab_pkg::slice_vec_t      ref_rd;
  rab_pkg::slice_vec_t      ref_wr;

  row_t   rows [N_ROWS];
  req_t   none;
  integer seed;

  rab_core dut_i (.*);

  initial
  begin
    Clk_CI = 1'b0;
    forever #20 Clk_CI = ~Clk_CI;  // 40 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_result(input rab_pkg::lookup_result_e got,
                              input rab_pkg::lookup_result_e exp);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t: lookup result %s, expected %s",
                          $time, got.name(), exp.name()));
  endtask

  task automatic check_addr(input rab_pkg::phys_addr_t got, input rab_pkg::phys_addr_t exp,
                            input string what);
    if (got !== exp)
      abort_run($sformatf("MISMATCH at %0t: %s %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_port(input logic got_port1, input logic exp_port1);
    if (got_port1 !== exp_port1)
      abort_run($sformatf("MISMATCH at %0t: served port%0d, expected port%0d",
                          $time, got_port1 ? 1 : 2, exp_port1 ? 1 : 2));
  endtask

  function automatic req_t burst(input rab_pkg::virt_addr_t addr, input rab_pkg::burst_len_t len,
                                 input rab_pkg::burst_size_t size, input logic write,
                                 input rab_pkg::user_t ctrl);
    req_t r;
    r.valid = 1'b1;
    r.addr  = addr;
    r.len   = len;
    r.size  = size;
    r.write = write;
    r.ctrl  = ctrl;
    return r;
  endfunction

  function automatic row_t entry(input req_t p1, input req_t p2,
                                 input rab_pkg::lookup_result_e res, input logic port1,
                                 input rab_pkg::phys_addr_t addr);
    row_t t;
    t.p1        = p1;
    t.p2        = p2;
    t.exp_res   = res;
    t.exp_port1 = port1;
    t.exp_addr  = addr;
    t.use_ref   = 1'b0;
    return t;
  endfunction

  // burst range and slice hit from the copied table
  function automatic rab_pkg::lookup_result_e ref_lookup(input req_t r,
                                                         output rab_pkg::phys_addr_t phys);
    int unsigned         lo;
    int                  hits;
    int                  idx;
    rab_pkg::virt_addr_t first;
    rab_pkg::virt_addr_t last;
    phys = '0;
    if (r.ctrl == '1)
    begin
      phys = rab_pkg::phys_addr_t'(r.addr);  // untranslated
      return HIT;
    end
    lo    = (r.size > `RAB_BEAT_BITS) ? `RAB_BEAT_BITS : r.size;
    first = (r.addr >> lo) << lo;
    last  = first + ((32'(r.len) + 32'd1) << r.size) - 32'd1;
    hits  = 0;
    idx   = 0;
    for (int s = 0; s < `RAB_N_SLICES; s++)
    begin
      if (ref_en[s] && ref_min[s] <= r.addr && last <= ref_max[s])
      begin
        hits++;
        idx = s;
      end
    end
    if (hits == 0)
      return MISS;
    if (hits > 1)
      return MULTI;
    if (!(r.write ? ref_wr[idx] : ref_rd[idx]))
      return PROT;
    phys = rab_pkg::phys_addr_t'(r.addr - ref_min[idx]) + ref_off[idx];
    return HIT;
  endfunction

  task automatic cfg_reg(input int s, input int offs, input rab_pkg::cfg_word_t data);
    @(posedge Clk_CI);
    cfg_wen   <= 1'b1;
    cfg_idx   <= rab_pkg::cfg_idx_t'(s * `RAB_REGS_PER_SLICE + offs);
    cfg_wdata <= data;
  endtask

  task automatic write_slice(input int s, input rab_pkg::virt_addr_t lo,
                             input rab_pkg::virt_addr_t hi, input rab_pkg::phys_addr_t off,
                             input logic en, input logic rd, input logic wr);
    rab_pkg::cfg_word_t flags;
    flags = '0;
    flags[`RAB_FLAG_EN] = en;
    flags[`RAB_FLAG_RD] = rd;
    flags[`RAB_FLAG_WR] = wr;
    cfg_reg(s, `RAB_REG_ADDR_MIN, rab_pkg::cfg_word_t'(lo));
    cfg_reg(s, `RAB_REG_ADDR_MAX, rab_pkg::cfg_word_t'(hi));
    cfg_reg(s, `RAB_REG_OFFSET, rab_pkg::cfg_word_t'(off));
    cfg_reg(s, `RAB_REG_FLAGS, flags);
    @(posedge Clk_CI);
    cfg_wen    <= 1'b0;
    ref_min[s] = lo;
    ref_max[s] = hi;
    ref_off[s] = off;
    ref_en[s]  = en;
    ref_rd[s]  = rd;
    ref_wr[s]  = wr;
  endtask

  task automatic drive_ports(input req_t a, input req_t b);
    port1_addr_valid <= a.valid;
    port1_addr       <= a.addr;
    port1_len        <= a.len;
    port1_size       <= a.size;
    port1_type       <= a.write;
    port1_ctrl       <= a.ctrl;
    port2_addr_valid <= b.valid;
    port2_addr       <= b.addr;
    port2_len        <= b.len;
    port2_size       <= b.size;
    port2_type       <= b.write;
    port2_ctrl       <= b.ctrl;
  endtask

  // one decision, then the master side of the handshake
  task automatic serve(input logic exp_port1, input rab_pkg::lookup_result_e exp_res,
                       input rab_pkg::phys_addr_t exp_addr, input bit timed);
    int                      cycles;
    int                      hold;
    int                      n_irq;
    logic                    got_port1;
    rab_pkg::lookup_result_e got_res;
    cycles = 0;
    do
    begin
      @(negedge Clk_CI);
      cycles++;
    end
    while (!(port1_accept || port1_drop || port2_accept || port2_drop));
    if (timed && cycles != 2)
      abort_run($sformatf("decision came %0d cycles after valid instead of one", cycles - 1));
    n_irq = int_miss + int_prot + int_multi;
    if ((port1_drop || port2_drop) && n_irq != 1)
      abort_run("burst dropped without exactly one interrupt");
    got_port1 = port1_accept || port1_drop;
    if (port1_accept || port2_accept)
      got_res = HIT;
    else if (int_prot)
      got_res = PROT;
    else if (int_multi)
      got_res = MULTI;
    else
      got_res = MISS;
    check_port(got_port1, exp_port1);
    check_result(got_res, exp_res);
    if (got_res == HIT)
      check_addr(got_port1 ? port1_out_addr : port2_out_addr, exp_addr, "accepted address");
    @(posedge Clk_CI);
    if (got_port1)
      port1_addr_valid <= 1'b0;
    else
      port2_addr_valid <= 1'b0;
    if (got_res == HIT)
    begin
      hold = 2 + ($random(seed) & 3);  // downstream latency
      repeat (hold)
      begin
        @(negedge Clk_CI);
        check_addr(got_port1 ? port1_out_addr : port2_out_addr, exp_addr, "held address");
      end
      @(posedge Clk_CI);
      port1_sent <= got_port1;
      port2_sent <= !got_port1;
      @(posedge Clk_CI);
      port1_sent <= 1'b0;
      port2_sent <= 1'b0;
    end
  endtask

  task automatic apply_row(input row_t r);
    req_t                    left;
    rab_pkg::lookup_result_e left_res;
    rab_pkg::phys_addr_t     left_addr;
    if (r.use_ref)
    begin
      r.exp_port1 = r.p1.valid;
      r.exp_res   = ref_lookup(r.p1.valid ? r.p1 : r.p2, r.exp_addr);
    end
    @(posedge Clk_CI);
    drive_ports(r.p1, r.p2);
    serve(r.exp_port1, r.exp_res, r.exp_addr, 1'b1);
    if (r.p1.valid && r.p2.valid)
    begin
      // the losing master keeps its request up
      left     = r.exp_port1 ? r.p2 : r.p1;
      left_res = ref_lookup(left, left_addr);
      serve(!r.exp_port1, left_res, left_addr, 1'b0);
    end
  endtask

  initial
  begin
    req_t req;
    seed    = 32'h85daeb1c;
    none    = burst(32'h0, 0, 0, 0, 0);
    none.valid = 1'b0;
    Rst_RBI    = 1'b0;
    cfg_wen    = 1'b0;
    cfg_idx    = '0;
    cfg_wdata  = '0;
    port1_sent = 1'b0;
    port2_sent = 1'b0;
    drive_ports(none, none);
    ref_en = '0;
    ref_rd = '0;
    ref_wr = '0;

    rows[0]  = entry(burst(32'h1000_0100, 3, 3, 0, 0), none, HIT, 1, 40'h80_0000_0100);
    rows[1]  = entry(none, burst(32'h1000_FFF0, 1, 3, 1, 0), HIT, 0, 40'h80_0000_FFF0);
    rows[2]  = entry(burst(32'h1000_FFF8, 1, 3, 0, 0), none, MISS, 1, 0);  // crosses max
    rows[3]  = entry(none, burst(32'h1000_FFFD, 0, 3, 0, 0), HIT, 0, 40'h80_0000_FFFD);
    rows[4]  = entry(burst(32'h5000_0000, 0, 2, 0, 0), none, MISS, 1, 0);
    rows[5]  = entry(none, burst(32'h2000_0010, 0, 2, 1, 0), PROT, 0, 0);   // read-only slice
    rows[6]  = entry(burst(32'h2000_0010, 0, 2, 0, 0), none, HIT, 1, 40'h00_4000_0010);
    rows[7]  = entry(none, burst(32'h3000_0900, 0, 2, 0, 0), MULTI, 0, 0);
    rows[8]  = entry(burst(32'h3000_1000, 3, 2, 0, 0), none, HIT, 1, 40'h20_0000_0800);
    rows[9]  = entry(burst(32'h1000_0200, 0, 3, 0, 0), burst(32'h1000_0300, 0, 3, 1, 0),
                     HIT, 0, 40'h80_0000_0300);
    rows[10] = entry(none, burst(32'h4000_0000, 0, 2, 0, 0), MISS, 0, 0);
    rows[11] = entry(burst(32'h3000_0000, 1, 2, 1, 0), burst(32'h7000_0004, 0, 2, 0, 6'h3F),
                     HIT, 1, 40'h10_0000_0000);
    rows[12] = entry(burst(32'h9000_0000, 15, 3, 0, 6'h3F), none, HIT, 1, 40'h00_9000_0000);
    rows[13] = entry(none, burst(32'h2000_0010, 0, 2, 1, 0), HIT, 0, 40'h00_5000_0010);
    rows[14] = entry(burst(32'h2000_0FF0, 3, 2, 0, 0), none, HIT, 1, 40'h00_5000_0FF0);
    for (int i = N_FIXED; i < N_ROWS; i++)
    begin
      req = burst(32'h1000_0000 + ($random(seed) & 32'h1_FFFF), $random(seed) & 8'h1F,
                  $random(seed) & 3, $random(seed) & 1, 0);
      rows[i] = entry((i % 2) ? none : req, (i % 2) ? req : none, MISS, 0, 0);
      rows[i].use_ref = 1'b1;
    end

    repeat (2) @(posedge Clk_CI);
    Rst_RBI <= 1'b1;

    write_slice(0, 32'h1000_0000, 32'h1000_FFFF, 40'h80_0000_0000, 1, 1, 1);
    write_slice(1, 32'h2000_0000, 32'h2000_0FFF, 40'h00_4000_0000, 1, 1, 0);
    write_slice(2, 32'h3000_0000, 32'h3000_0FFF, 40'h10_0000_0000, 1, 1, 1);
    write_slice(3, 32'h3000_0800, 32'h3000_1FFF, 40'h20_0000_0000, 1, 1, 1);  // overlaps 2

    for (int i = 0; i < N_ROWS; i++)
    begin
      if (i == REPROG_ROW)
        write_slice(1, 32'h2000_0000, 32'h2000_0FFF, 40'h00_5000_0000, 1, 1, 1);
      apply_row(rows[i]);
    end
    @(negedge Clk_CI);  // assertions of the last edge have run
    $display("sim passed");
    $finish;
  end

  // handshake properties bound into the DUT
  initial
  begin
    wait (dut_i.props_i.fail_cnt != 0);
    abort_run("a handshake property of rab_core failed");
  end

  // watchdog, 20 cycles per row and per configuration write
  initial
  begin
    repeat ((N_ROWS + N_CFG) * 20) @(posedge Clk_CI);
    abort_run($sformatf("timeout: test not done after %0d cycles", (N_ROWS + N_CFG) * 20));
  end

endmodule
